//--- hdl/dl11_pkg.sv
/*
 * Shared definitions for the DL11 console line.
 * Everything runs on one clock; the baud rate comes from clock-enable divisors.
 */
package dl11_pkg;

   typedef logic [12:0] iopage_addr_t;
   typedef logic [15:0] word_t;
   typedef logic [7:0]  byte_t;
   typedef logic [7:0]  vector_t;

   // I/O-page word addresses of the four registers
   localparam iopage_addr_t TTI_CSR_ADDR = 13'o17560;
   localparam iopage_addr_t TTI_BUF_ADDR = 13'o17562;
   localparam iopage_addr_t TTO_CSR_ADDR = 13'o17564;
   localparam iopage_addr_t TTO_BUF_ADDR = 13'o17566;

   localparam vector_t RX_VECTOR = 8'o060;
   localparam vector_t TX_VECTOR = 8'o064;

   localparam int CSR_READY_BIT = 7;
   localparam int CSR_IE_BIT    = 6;

   // clocks per oversample tick, oversample ticks per bit
   localparam int BAUD_DIV   = 4;
   localparam int OVERSAMPLE = 16;

   localparam int DIV_CNT_W = $clog2(BAUD_DIV);
   localparam int OS_CNT_W  = $clog2(OVERSAMPLE);
   localparam logic [DIV_CNT_W-1:0] DIV_LAST = DIV_CNT_W'(BAUD_DIV - 1);
   localparam logic [OS_CNT_W-1:0]  OS_LAST  = OS_CNT_W'(OVERSAMPLE - 1);
   localparam logic [OS_CNT_W-1:0]  OS_HALF  = OS_CNT_W'(OVERSAMPLE / 2 - 1);

   typedef enum logic [1:0] {TTO_IDLE, TTO_LOAD, TTO_ACK_DROP, TTO_WAIT_EMPTY} tto_state_t;
   typedef enum logic [1:0] {TTI_IDLE, TTI_UNLOAD, TTI_ACK_DROP, TTI_FULL} tti_state_t;
   typedef enum logic [1:0] {TX_IDLE, TX_START, TX_DATA, TX_STOP} tx_state_t;
   typedef enum logic [1:0] {RX_IDLE, RX_START, RX_DATA, RX_STOP} rx_state_t;

endpackage

//--- hdl/uart_xfer_if.sv
/*
 * One load or unload path between the register block and a UART half.
 * Four-phase req/ack: req up, ack up, req down, ack down.
 */
`timescale 1ns/1ps

interface uart_xfer_if
   import dl11_pkg::*;
();

   logic  req;
   logic  ack;
   logic  empty;
   byte_t data;

   // host pushes a character into the transmitter
   modport load_host (
      output req,
      output data,
      input  ack,
      input  empty
   );

   modport load_uart (
      input  req,
      input  data,
      output ack,
      output empty
   );

   // host pulls a character out of the receiver
   modport unload_host (
      output req,
      input  ack,
      input  data,
      input  empty
   );

   modport unload_uart (
      input  req,
      output ack,
      output data,
      output empty
   );

endinterface

//--- hdl/baud_gen.sv
/*
 * Baud tick generator. Both outputs are single-cycle clock enables.
 * One bit time is BAUD_DIV * OVERSAMPLE clocks.
 */
`timescale 1ns/1ps

module baud_gen
   import dl11_pkg::*;
(
   input  logic clk,
   input  logic reset,
   output logic os_tick,
   output logic bit_tick
);

   logic [DIV_CNT_W-1:0] div_cnt;
   logic [OS_CNT_W-1:0]  os_cnt;

   assign os_tick  = (div_cnt == DIV_LAST);
   assign bit_tick = os_tick && (os_cnt == OS_LAST);

   always_ff @(posedge clk)
   begin
      if (reset)
      begin
         div_cnt <= '0;
         os_cnt  <= '0;
      end
      else
      begin
         div_cnt <= os_tick ? '0 : div_cnt + 1'b1;
         // oversample count advances once per os_tick
         if (bit_tick)
            os_cnt <= '0;
         else if (os_tick)
            os_cnt <= os_cnt + 1'b1;
      end
   end

endmodule

//--- hdl/uart_tx.sv
/*
 * 8N1 transmitter, LSB first, one bit per bit_tick.
 * A character is accepted only while empty; empty returns after the stop bit.
 */
`timescale 1ns/1ps

module uart_tx
   import dl11_pkg::*;
(
   input  logic             clk,
   input  logic             reset,
   input  logic             bit_tick,
   uart_xfer_if.load_uart   link,
   output logic             tx_out
);

   tx_state_t  state;
   byte_t      shift;
   logic [2:0] bit_cnt;
   logic       load;

   assign load = link.req && link.empty && !link.ack;

   // character register, shifted out as bits go on the line
   always_ff @(posedge clk)
   begin
      if (load)
         shift <= link.data;
      else if (bit_tick && (state == TX_START || state == TX_DATA))
         shift <= shift >> 1;
   end

   always_ff @(posedge clk)
   begin
      if (reset)
      begin
         state      <= TX_IDLE;
         tx_out     <= 1'b1;
         bit_cnt    <= '0;
         link.ack   <= 1'b0;
         link.empty <= 1'b1;
      end
      else
      begin
         if (load)
         begin
            link.ack   <= 1'b1;
            link.empty <= 1'b0;
         end
         else if (!link.req)
            link.ack <= 1'b0;

         if (bit_tick)
         begin
            unique case (state)
               TX_IDLE:
                  if (!link.empty)
                  begin
                     state  <= TX_START;
                     tx_out <= 1'b0;
                  end
               TX_START:
               begin
                  state   <= TX_DATA;
                  tx_out  <= shift[0];
                  bit_cnt <= '0;
               end
               TX_DATA:
                  if (bit_cnt == 3'd7)
                  begin
                     state  <= TX_STOP;
                     tx_out <= 1'b1;
                  end
                  else
                  begin
                     tx_out  <= shift[0];
                     bit_cnt <= bit_cnt + 1'b1;
                  end
               TX_STOP:
               begin
                  state      <= TX_IDLE;
                  link.empty <= 1'b1;
               end
            endcase
         end
      end
   end

endmodule

//--- hdl/uart_rx.sv
/*
 * 8N1 receiver with 16x oversampling. A frame with a low stop bit is dropped.
 * No overrun flag: a new character overwrites one that was not unloaded.
 */
`timescale 1ns/1ps

module uart_rx
   import dl11_pkg::*;
(
   input  logic              clk,
   input  logic              reset,
   input  logic              os_tick,
   input  logic              rx_in,
   uart_xfer_if.unload_uart  link
);

   rx_state_t           state;
   logic                rx_meta;
   logic                rx_sync;
   logic                rx_prev;
   logic [OS_CNT_W-1:0] os_cnt;
   logic [2:0]          bit_cnt;
   logic                mid_bit;
   logic                frame_ok;
   byte_t               shift;
   byte_t               hold;

   assign mid_bit  = os_tick && (os_cnt == OS_LAST);
   assign frame_ok = (state == RX_STOP) && mid_bit && rx_sync;
   assign link.data = hold;

   // two-flop synchronizer plus one stage for edge detect
   always_ff @(posedge clk)
   begin
      if (reset)
      begin
         rx_meta <= 1'b1;
         rx_sync <= 1'b1;
         rx_prev <= 1'b1;
      end
      else
      begin
         rx_meta <= rx_in;
         rx_sync <= rx_meta;
         rx_prev <= rx_sync;
      end
   end

   always_ff @(posedge clk)
   begin
      if (reset)
      begin
         state   <= RX_IDLE;
         os_cnt  <= '0;
         bit_cnt <= '0;
      end
      else
      begin
         unique case (state)
            RX_IDLE:
               if (rx_prev && !rx_sync)
               begin
                  state  <= RX_START;
                  os_cnt <= '0;
               end
            RX_START:
               if (os_tick)
               begin
                  os_cnt <= os_cnt + 1'b1;
                  // half a bit later the line must still be low
                  if (os_cnt == OS_HALF)
                  begin
                     os_cnt  <= '0;
                     bit_cnt <= '0;
                     state   <= rx_sync ? RX_IDLE : RX_DATA;
                  end
               end
            RX_DATA:
               if (os_tick)
               begin
                  os_cnt <= os_cnt + 1'b1;
                  if (mid_bit)
                  begin
                     bit_cnt <= bit_cnt + 1'b1;
                     if (bit_cnt == 3'd7)
                        state <= RX_STOP;
                  end
               end
            RX_STOP:
               if (os_tick)
               begin
                  os_cnt <= os_cnt + 1'b1;
                  if (mid_bit)
                     state <= RX_IDLE;
               end
         endcase
      end
   end

   always_ff @(posedge clk)
   begin
      if (state == RX_DATA && mid_bit)
         shift <= {rx_sync, shift[7:1]};
      if (frame_ok)
         hold <= shift;
   end

   always_ff @(posedge clk)
   begin
      if (reset)
      begin
         link.ack   <= 1'b0;
         link.empty <= 1'b1;
      end
      else
      begin
         if (link.req && !link.ack)
         begin
            link.ack   <= 1'b1;
            link.empty <= 1'b1;
         end
         else if (!link.req)
            link.ack <= 1'b0;
         // a fresh frame wins over an unload in the same cycle
         if (frame_ok)
            link.empty <= 1'b0;
      end
   end

endmodule

//--- hdl/dl11_regs.sv
/*
 * DL11 register block: CSR/buffer decode, tto and tti sequencers, interrupt.
 * Reads are combinational. An odd byte write shifts the high data byte down.
 * TTO_BUF writes while not ready change the register but send nothing.
 */
`timescale 1ns/1ps

module dl11_regs
   import dl11_pkg::*;
(
   input  logic                    clk,
   input  logic                    reset,
   input  iopage_addr_t            iopage_addr,
   input  word_t                   data_in,
   input  logic                    iopage_rd,
   input  logic                    iopage_wr,
   input  logic                    iopage_byte_op,
   output word_t                   data_out,
   output logic                    decode,
   output logic                    interrupt,
   output vector_t                 vector,
   uart_xfer_if.load_host          tx_link,
   uart_xfer_if.unload_host        rx_link
);

   tto_state_t tto_state;
   tto_state_t tto_next;
   tti_state_t tti_state;
   tti_state_t tti_next;
   logic       tti_csr_sel;
   logic       tti_buf_sel;
   logic       tto_csr_sel;
   logic       tto_buf_sel;
   logic       rx_ie;
   logic       tx_ie;
   logic       tto_ready;
   logic       tti_ready;
   logic       rx_int;
   logic       tx_int;
   word_t      tti_csr;
   word_t      tto_csr;
   word_t      reg_in;
   word_t      reg_out;
   word_t      tto_data;
   byte_t      tti_data;

   // byte lanes share a word, so bit 0 is left out of the match
   assign tti_csr_sel = (iopage_addr[12:1] == TTI_CSR_ADDR[12:1]);
   assign tti_buf_sel = (iopage_addr[12:1] == TTI_BUF_ADDR[12:1]);
   assign tto_csr_sel = (iopage_addr[12:1] == TTO_CSR_ADDR[12:1]);
   assign tto_buf_sel = (iopage_addr[12:1] == TTO_BUF_ADDR[12:1]);
   assign decode = tti_csr_sel || tti_buf_sel || tto_csr_sel || tto_buf_sel;

   always_comb
   begin
      tti_csr = '0;
      tti_csr[CSR_READY_BIT] = tti_ready;
      tti_csr[CSR_IE_BIT] = rx_ie;
      tto_csr = '0;
      tto_csr[CSR_READY_BIT] = tto_ready;
      tto_csr[CSR_IE_BIT] = tx_ie;

      reg_out = '0;
      if (iopage_rd && tti_csr_sel)
         reg_out = tti_csr;
      else if (iopage_rd && tti_buf_sel)
         reg_out = {8'b0, tti_data};
      else if (iopage_rd && tto_csr_sel)
         reg_out = tto_csr;
      else if (iopage_rd && tto_buf_sel)
         reg_out = tto_data;
   end

   assign data_out = iopage_byte_op ?
                     {8'b0, iopage_addr[0] ? reg_out[15:8] : reg_out[7:0]} : reg_out;
   assign reg_in = (iopage_byte_op && iopage_addr[0]) ? {8'b0, data_in[15:8]} : data_in;

   always_ff @(posedge clk)
   begin
      if (reset)
      begin
         rx_ie <= 1'b0;
         tx_ie <= 1'b0;
      end
      else if (iopage_wr)
      begin
         if (tti_csr_sel)
            rx_ie <= reg_in[CSR_IE_BIT];
         if (tto_csr_sel)
            tx_ie <= reg_in[CSR_IE_BIT];
      end
   end

   always_ff @(posedge clk)
   begin
      if (iopage_wr && tto_buf_sel)
         tto_data <= reg_in;
      if (!rx_link.empty)
         tti_data <= rx_link.data;
   end

   // tto: push the character, then hold ready low until the frame is out
   always_comb
   begin
      tto_next = tto_state;
      unique case (tto_state)
         TTO_IDLE:       if (iopage_wr && tto_buf_sel) tto_next = TTO_LOAD;
         TTO_LOAD:       if (tx_link.ack) tto_next = TTO_ACK_DROP;
         TTO_ACK_DROP:   if (!tx_link.ack) tto_next = TTO_WAIT_EMPTY;
         TTO_WAIT_EMPTY: if (tx_link.empty) tto_next = TTO_IDLE;
      endcase
   end

   // tti: pull the character out, then stay full until software reads it
   always_comb
   begin
      tti_next = tti_state;
      unique case (tti_state)
         TTI_IDLE:     if (!rx_link.empty) tti_next = TTI_UNLOAD;
         TTI_UNLOAD:   if (rx_link.ack) tti_next = TTI_ACK_DROP;
         TTI_ACK_DROP: if (!rx_link.ack) tti_next = TTI_FULL;
         // only a read of the low byte consumes the character
         TTI_FULL:     if (iopage_rd && tti_buf_sel && !iopage_addr[0]) tti_next = TTI_IDLE;
      endcase
   end

   always_ff @(posedge clk)
   begin
      if (reset)
      begin
         tto_state <= TTO_IDLE;
         tti_state <= TTI_IDLE;
         interrupt <= 1'b0;
      end
      else
      begin
         tto_state <= tto_next;
         tti_state <= tti_next;
         interrupt <= rx_int || tx_int;
      end
   end

   assign tx_link.req  = (tto_state == TTO_LOAD);
   assign tx_link.data = tto_data[7:0];
   assign rx_link.req  = (tti_state == TTI_UNLOAD);
   assign tto_ready    = (tto_state == TTO_IDLE);
   assign tti_ready    = (tti_state == TTI_FULL);

   // receive wins when both want service
   assign rx_int = rx_ie && tti_ready;
   assign tx_int = tx_ie && tto_ready;
   assign vector = rx_int ? RX_VECTOR : tx_int ? TX_VECTOR : '0;

endmodule

//--- hdl/dl11_console.sv
/*
 * DL11 console serial line for the PDP-11 I/O page, 8N1, single clock.
 * Interrupt is a level that follows its condition; there is no acknowledge.
 */
`timescale 1ns/1ps

module dl11_console
   import dl11_pkg::*;
(
   input  logic         clk,
   input  logic         reset,
   input  logic         rs232_rx,
   input  iopage_addr_t iopage_addr,
   input  word_t        data_in,
   input  logic         iopage_rd,
   input  logic         iopage_wr,
   input  logic         iopage_byte_op,
   output word_t        data_out,
   output logic         decode,
   output logic         interrupt,
   output vector_t      vector,
   output logic         rs232_tx
);

   logic os_tick;
   logic bit_tick;

   uart_xfer_if tx_link ();
   uart_xfer_if rx_link ();

   dl11_regs u_regs (
      .clk            (clk),
      .reset          (reset),
      .iopage_addr    (iopage_addr),
      .data_in        (data_in),
      .iopage_rd      (iopage_rd),
      .iopage_wr      (iopage_wr),
      .iopage_byte_op (iopage_byte_op),
      .data_out       (data_out),
      .decode         (decode),
      .interrupt      (interrupt),
      .vector         (vector),
      .tx_link        (tx_link),
      .rx_link        (rx_link)
   );

   baud_gen u_baud (
      .clk      (clk),
      .reset    (reset),
      .os_tick  (os_tick),
      .bit_tick (bit_tick)
   );

   uart_tx u_tx (
      .clk      (clk),
      .reset    (reset),
      .bit_tick (bit_tick),
      .link     (tx_link),
      .tx_out   (rs232_tx)
   );

   uart_rx u_rx (
      .clk     (clk),
      .reset   (reset),
      .os_tick (os_tick),
      .rx_in   (rs232_rx),
      .link    (rx_link)
   );

endmodule

//--- tests/dl11_asserts.sv
/*
 * Concurrent checks on the register block, attached by bind to every dl11_regs.
 * The interrupt lags its condition by one clock, so right after a bus access
 * the vector may already read 0 while the interrupt is still high.
 */
`timescale 1ns/1ps

module dl11_asserts
   import dl11_pkg::*;
(
   input logic    clk,
   input logic    reset,
   input logic    iopage_rd,
   input logic    iopage_wr,
   input logic    tx_req,
   input logic    tx_ack,
   input logic    rx_req,
   input logic    rx_ack,
   input logic    interrupt,
   input vector_t vector
);

   // a request is held until the UART answers
   tx_req_held: assert property (@(posedge clk) disable iff (reset)
      tx_req && !tx_ack |=> tx_req)
      else $error("tx load request dropped before ack");

   rx_req_held: assert property (@(posedge clk) disable iff (reset)
      rx_req && !rx_ack |=> rx_req)
      else $error("rx unload request dropped before ack");

   tx_ack_after_req: assert property (@(posedge clk) disable iff (reset)
      $rose(tx_ack) |-> $past(tx_req))
      else $error("tx ack rose without a request");

   rx_ack_after_req: assert property (@(posedge clk) disable iff (reset)
      $rose(rx_ack) |-> $past(rx_req))
      else $error("rx ack rose without a request");

   int_low_after_reset: assert property (@(posedge clk)
      reset |=> !interrupt)
      else $error("interrupt high in the cycle after reset");

   // conditions fall only after a bus access
   // at any other time a raised interrupt must carry a vector
   int_has_vector: assert property (@(posedge clk) disable iff (reset)
      interrupt && !$past(iopage_rd || iopage_wr) |-> vector != 8'd0)
      else $error("interrupt raised with a zero vector");

endmodule

bind dl11_regs dl11_asserts u_asserts (
   .clk       (clk),
   .reset     (reset),
   .iopage_rd (iopage_rd),
   .iopage_wr (iopage_wr),
   .tx_req    (tx_link.req),
   .tx_ack    (tx_link.ack),
   .rx_req    (rx_link.req),
   .rx_ack    (rx_link.ack),
   .interrupt (interrupt),
   .vector    (vector)
);

//--- tests/dl11_console_tb.sv
/*
 * Testbench for the DL11 console line. Serial frames run at 64 clocks per bit.
 * Inputs change 1 ns after the rising edge, outputs are sampled on the falling edge.
 */
`timescale 1ns/1ps

module dl11_console_tb
   import dl11_pkg::*;
();

   localparam int BIT_CLKS    = BAUD_DIV * OVERSAMPLE;
   localparam int POLL_LIMIT  = 1000;
   localparam int INT_LIMIT   = 16;
   localparam int START_LIMIT = 4 * BIT_CLKS;
   localparam iopage_addr_t UNMAPPED_ADDR = 13'o17570;

   typedef enum logic [2:0] {OP_TRANSMIT, OP_RECEIVE, OP_ENABLES, OP_BYTE_READ, OP_BYTE_IE} op_t;

   // mid values apply while a character is in flight or pending
   typedef struct packed {
      op_t        kind;
      byte_t      ch;
      logic [1:0] ie;
      word_t      exp_word;
      vector_t    vec_mid;
      logic       int_mid;
      vector_t    vec_end;
      logic       int_end;
   } row_t;

   logic         clk = 1'b0;
   logic         reset;
   logic         rs232_rx;
   iopage_addr_t iopage_addr;
   word_t        data_in;
   logic         iopage_rd;
   logic         iopage_wr;
   logic         iopage_byte_op;
   word_t        data_out;
   logic         decode;
   logic         interrupt;
   vector_t      vector;
   logic         rs232_tx;
   row_t         rows[$];
   int           seed;
   logic         run_done;
   logic         fail_printed;

   dl11_console u_dut (
      .clk            (clk),
      .reset          (reset),
      .rs232_rx       (rs232_rx),
      .iopage_addr    (iopage_addr),
      .data_in        (data_in),
      .iopage_rd      (iopage_rd),
      .iopage_wr      (iopage_wr),
      .iopage_byte_op (iopage_byte_op),
      .data_out       (data_out),
      .decode         (decode),
      .interrupt      (interrupt),
      .vector         (vector),
      .rs232_tx       (rs232_tx)
   );

   always #10 clk = ~clk;

   task automatic abort_run();
      fail_printed = 1'b1;
      $display("sim failed");
      $fatal(1, "test stopped at the first error");
   endtask

   task automatic timeout_fail(input string what);
      $display("timeout while waiting for %s", what);
      abort_run();
   endtask

   task automatic check_word(input string what, input word_t expected, input word_t actual);
      if (actual !== expected)
      begin
         $display("[ERROR] %0t ns: %s expected %o, got %o", $time, what, expected, actual);
         abort_run();
      end
   endtask

   task automatic check_byte(input string what, input byte_t expected, input byte_t actual);
      if (actual !== expected)
      begin
         $display("[ERROR] %0t ns: %s expected %h, got %h", $time, what, expected, actual);
         abort_run();
      end
   endtask

   task automatic check_vector(input string what, input vector_t expected, input vector_t actual);
      if (actual !== expected)
      begin
         $display("[ERROR] %0t ns: %s expected %o, got %o", $time, what, expected, actual);
         abort_run();
      end
   endtask

   task automatic check_bit(input string what, input logic expected, input logic actual);
      if (actual !== expected)
      begin
         $display("[ERROR] %0t ns: %s expected %b, got %b", $time, what, expected, actual);
         abort_run();
      end
   endtask

   function automatic word_t ie_word(input logic en);
      word_t w;
      w = '0;
      w[CSR_IE_BIT] = en;
      return w;
   endfunction

   // read data is combinational, sampled mid-cycle
   task automatic bus_read(input iopage_addr_t addr, input logic byte_op,
                           output word_t data, output logic hit);
      @(posedge clk);
      #1;
      iopage_addr    = addr;
      iopage_byte_op = byte_op;
      iopage_rd      = 1'b1;
      @(negedge clk);
      data = data_out;
      hit  = decode;
      @(posedge clk);
      #1;
      iopage_rd      = 1'b0;
      iopage_byte_op = 1'b0;
   endtask

   task automatic bus_write(input iopage_addr_t addr, input logic byte_op, input word_t data);
      @(posedge clk);
      #1;
      iopage_addr    = addr;
      data_in        = data;
      iopage_byte_op = byte_op;
      iopage_wr      = 1'b1;
      @(posedge clk);
      #1;
      iopage_wr      = 1'b0;
      iopage_byte_op = 1'b0;
   endtask

   task automatic poll_ready(input iopage_addr_t csr_addr, input string what, output word_t data);
      int   polls;
      logic hit;
      polls = 0;
      bus_read(csr_addr, 1'b0, data, hit);
      while (data[CSR_READY_BIT] !== 1'b1)
      begin
         polls++;
         if (polls > POLL_LIMIT)
            timeout_fail(what);
         bus_read(csr_addr, 1'b0, data, hit);
      end
   endtask

   task automatic wait_interrupt(input logic level);
      int cycles;
      cycles = 0;
      while (interrupt !== level)
      begin
         @(negedge clk);
         cycles++;
         if (cycles > INT_LIMIT)
            timeout_fail("the interrupt level to settle");
      end
   endtask

   // start bit, eight data bits LSB first, stop bit
   task automatic send_frame(input byte_t ch);
      logic [9:0] frame;
      frame = {1'b1, ch, 1'b0};
      for (int i = 0; i < 10; i++)
      begin
         @(posedge clk);
         #1;
         rs232_rx = frame[i];
         repeat (BIT_CLKS - 1) @(posedge clk);
      end
   endtask

   task automatic decode_frame(output byte_t ch);
      int waited;
      waited = 0;
      ch = '0;
      while (rs232_tx !== 1'b0)
      begin
         @(negedge clk);
         waited++;
         if (waited > START_LIMIT)
            timeout_fail("a start bit on rs232_tx");
      end
      // move to the middle of the start bit
      repeat (BIT_CLKS / 2) @(negedge clk);
      check_bit("start bit on rs232_tx", 1'b0, rs232_tx);
      for (int i = 0; i < 8; i++)
      begin
         repeat (BIT_CLKS) @(negedge clk);
         ch[i] = rs232_tx;
      end
      repeat (BIT_CLKS) @(negedge clk);
      check_bit("stop bit on rs232_tx", 1'b1, rs232_tx);
   endtask

   task automatic add_row(input op_t kind, input byte_t ch, input logic [1:0] ie,
                          input word_t exp_word, input vector_t vec_mid, input logic int_mid,
                          input vector_t vec_end, input logic int_end);
      row_t r;
      r.kind     = kind;
      r.ch       = ch;
      r.ie       = ie;
      r.exp_word = exp_word;
      r.vec_mid  = vec_mid;
      r.int_mid  = int_mid;
      r.vec_end  = vec_end;
      r.int_end  = int_end;
      rows.push_back(r);
   endtask

   task automatic check_reset();
      word_t data;
      logic  hit;
      bus_read(TTO_CSR_ADDR, 1'b0, data, hit);
      check_word("TTO CSR after reset", 16'o200, data);
      check_bit("decode of TTO CSR", 1'b1, hit);
      bus_read(TTI_CSR_ADDR, 1'b0, data, hit);
      check_word("TTI CSR after reset", 16'o0, data);
      check_bit("interrupt after reset", 1'b0, interrupt);
      check_vector("vector after reset", 8'o0, vector);
      bus_read(UNMAPPED_ADDR, 1'b0, data, hit);
      check_bit("decode of unmapped address", 1'b0, hit);
      check_word("data of unmapped address", 16'o0, data);
   endtask

   task automatic run_transmit(input row_t row);
      word_t data;
      logic  hit;
      byte_t got;
      bus_write(TTO_BUF_ADDR, 1'b0, {8'h00, row.ch});
      bus_read(TTO_CSR_ADDR, 1'b0, data, hit);
      check_bit("TTO ready after buffer write", 1'b0, data[CSR_READY_BIT]);
      wait_interrupt(row.int_mid);
      check_vector("vector while sending", row.vec_mid, vector);
      decode_frame(got);
      check_byte("character on rs232_tx", row.ch, got);
      bus_read(TTO_CSR_ADDR, 1'b0, data, hit);
      check_bit("TTO ready during stop bit", 1'b0, data[CSR_READY_BIT]);
      poll_ready(TTO_CSR_ADDR, "TTO ready after a frame", data);
      check_word("TTO CSR after the frame", row.exp_word, data);
   endtask

   task automatic run_receive(input row_t row);
      word_t data;
      logic  hit;
      send_frame(row.ch);
      poll_ready(TTI_CSR_ADDR, "TTI ready after a frame", data);
      wait_interrupt(row.int_mid);
      check_vector("vector with a character pending", row.vec_mid, vector);
      bus_read(TTI_BUF_ADDR, 1'b0, data, hit);
      check_word("TTI buffer", {8'h00, row.ch}, data);
      bus_read(TTI_CSR_ADDR, 1'b0, data, hit);
      check_word("TTI CSR after buffer read", row.exp_word, data);
   endtask

   task automatic run_enables(input row_t row);
      word_t data;
      logic  hit;
      bus_write(TTI_CSR_ADDR, 1'b0, ie_word(row.ie[1]));
      bus_write(TTO_CSR_ADDR, 1'b0, ie_word(row.ie[0]));
      bus_read(TTO_CSR_ADDR, 1'b0, data, hit);
      check_word("TTO CSR after enable write", row.exp_word, data);
      bus_read(TTI_CSR_ADDR, 1'b0, data, hit);
      check_bit("TTI interrupt enable", row.ie[1], data[CSR_IE_BIT]);
   endtask

   task automatic run_byte_read(input row_t row);
      word_t data;
      logic  hit;
      send_frame(row.ch);
      poll_ready(TTI_CSR_ADDR, "TTI ready before byte reads", data);
      wait_interrupt(row.int_mid);
      check_vector("vector before byte reads", row.vec_mid, vector);
      bus_read(TTI_BUF_ADDR | 13'o1, 1'b1, data, hit);
      check_byte("odd byte of TTI buffer", 8'h00, data[7:0]);
      check_byte("upper lane of odd byte read", 8'h00, data[15:8]);
      // the odd byte must leave the character pending
      bus_read(TTI_CSR_ADDR, 1'b0, data, hit);
      check_bit("TTI ready after odd byte read", 1'b1, data[CSR_READY_BIT]);
      bus_read(TTI_BUF_ADDR, 1'b1, data, hit);
      check_byte("even byte of TTI buffer", row.ch, data[7:0]);
      check_byte("upper lane of even byte read", 8'h00, data[15:8]);
      bus_read(TTI_CSR_ADDR, 1'b0, data, hit);
      check_word("TTI CSR after byte read", row.exp_word, data);
   endtask

   task automatic run_byte_ie(input row_t row);
      word_t data;
      logic  hit;
      // upper byte is junk, only the enable bit may land
      bus_write(TTO_CSR_ADDR, 1'b1, 16'hff00 | ie_word(row.ie[0]));
      bus_read(TTO_CSR_ADDR, 1'b0, data, hit);
      check_word("TTO CSR after byte write", row.exp_word, data);
   endtask

   task automatic check_end(input row_t row);
      wait_interrupt(row.int_end);
      check_vector("vector after the row", row.vec_end, vector);
   endtask

   initial
   begin
      byte_t rand_a;
      byte_t rand_b;
      reset          = 1'b1;
      rs232_rx       = 1'b1;
      iopage_addr    = '0;
      data_in        = '0;
      iopage_rd      = 1'b0;
      iopage_wr      = 1'b0;
      iopage_byte_op = 1'b0;
      run_done       = 1'b0;
      fail_printed   = 1'b0;
      seed           = 94490;
      rand_a = byte_t'($random(seed));
      rand_b = byte_t'($random(seed));

      repeat (10) @(posedge clk);
      #1;
      reset = 1'b0;
      check_reset();

      // kind, char, ie {rx,tx}, word, mid vector, mid int, end vector, end int
      add_row(OP_TRANSMIT,  8'h55,  2'b00, 16'o200, 8'o0,   1'b0, 8'o0,   1'b0);
      add_row(OP_TRANSMIT,  rand_a, 2'b00, 16'o200, 8'o0,   1'b0, 8'o0,   1'b0);
      add_row(OP_RECEIVE,   8'ha3,  2'b00, 16'o0,   8'o0,   1'b0, 8'o0,   1'b0);
      add_row(OP_RECEIVE,   rand_b, 2'b00, 16'o0,   8'o0,   1'b0, 8'o0,   1'b0);
      add_row(OP_ENABLES,   8'h00,  2'b01, 16'o300, 8'o0,   1'b0, 8'o064, 1'b1);
      add_row(OP_TRANSMIT,  8'h0d,  2'b01, 16'o300, 8'o0,   1'b0, 8'o064, 1'b1);
      add_row(OP_ENABLES,   8'h00,  2'b00, 16'o200, 8'o0,   1'b0, 8'o0,   1'b0);
      add_row(OP_ENABLES,   8'h00,  2'b11, 16'o300, 8'o0,   1'b0, 8'o064, 1'b1);
      add_row(OP_RECEIVE,   8'h7e,  2'b11, 16'o100, 8'o060, 1'b1, 8'o064, 1'b1);
      add_row(OP_ENABLES,   8'h00,  2'b00, 16'o200, 8'o0,   1'b0, 8'o0,   1'b0);
      add_row(OP_BYTE_READ, 8'hc4,  2'b00, 16'o0,   8'o0,   1'b0, 8'o0,   1'b0);
      add_row(OP_BYTE_IE,   8'h00,  2'b01, 16'o300, 8'o0,   1'b0, 8'o064, 1'b1);
      add_row(OP_ENABLES,   8'h00,  2'b00, 16'o200, 8'o0,   1'b0, 8'o0,   1'b0);

      for (int k = 0; k < rows.size(); k++)
      begin
         case (rows[k].kind)
            OP_TRANSMIT:  run_transmit(rows[k]);
            OP_RECEIVE:   run_receive(rows[k]);
            OP_ENABLES:   run_enables(rows[k]);
            OP_BYTE_READ: run_byte_read(rows[k]);
            OP_BYTE_IE:   run_byte_ie(rows[k]);
            default:
            begin
               $display("row %0d has an unknown operation kind", k);
               abort_run();
            end
         endcase
         check_end(rows[k]);
         $display("row %0d done at %0t ns", k, $time);
      end

      run_done = 1'b1;
      $display("sim passed");
      $finish;
   end

   // a run stopped before the table finished still ends with the fail line
   final
   begin
      if (!run_done && !fail_printed)
         $display("sim failed");
   end

endmodule

//--- flist.f
hdl/dl11_pkg.sv
hdl/uart_xfer_if.sv
hdl/baud_gen.sv
hdl/uart_tx.sv
hdl/uart_rx.sv
hdl/dl11_regs.sv
hdl/dl11_console.sv
tests/dl11_asserts.sv
tests/dl11_console_tb.sv

//--- run_sim.sh
#!/bin/sh
# build and run the DL11 console testbench with Verilator; exit status is the result
cd "$(dirname "$0")" &&
verilator --binary --timing --assert --timescale 1ns/1ps \
   --top-module dl11_console_tb -f flist.f -o dl11_console_sim &&
./obj_dir/dl11_console_sim || exit 1
